/* Bender.yml */
package:
  name: horizontal_stretch

sources:
  - files:
      - scalerPkg.sv
      - scalerCoordGen.sv
      - scalerPixelWindow.sv
      - scalerBlend.sv
      - scalerOutputPort.sv
      - horizontalStretch.sv
  - target: simulation
    files:
      - tbHorizontalStretch.sv

/* build.f */
scalerPkg.sv
scalerCoordGen.sv
scalerPixelWindow.sv
scalerBlend.sv
scalerOutputPort.sv
horizontalStretch.sv
tbHorizontalStretch.sv

/* horizontalStretch.sv */
/*
 * Horizontal line scaler top level chaining coordinate generation,
 * pixel window, blend and output port
 */
`timescale 1ns/100ps

module horizontalStretch import scalerPkg::*; (
    input  logic    scalerClock,
    input  logic    reset,
    input  logic    start,
    input  shrink_t shrinkFactor,
    input  column_t outputWidth,
    output logic    busy,
    output logic    pixelReq,
    input  logic    pixelAck,
    input  pixel_t  upstreamPixel,
    output pixel_t  outPixel,
    output logic    outReq,
    input  logic    outAck
);

    // Coordinate stage to window
    coordItem_t coordItem;
    logic coordValid;
    logic coordReady;

    // Window to blend stage
    blendItem_t blendItem;
    logic blendValid;
    logic blendReady;

    // Blend stage to output port
    outItem_t outItem;
    logic outValid;
    logic outReady;

    // End of line from the output port back to the busy flag
    logic lineDone;

    scalerCoordGen scalerCoordGen_inst (
        .scalerClock  (scalerClock),
        .reset        (reset),
        .start        (start),
        .shrinkFactor (shrinkFactor),
        .outputWidth  (outputWidth),
        .busy         (busy),
        .lineDone     (lineDone),
        .coordItem    (coordItem),
        .coordValid   (coordValid),
        .coordReady   (coordReady)
    );

    scalerPixelWindow scalerPixelWindow_inst (
        .scalerClock   (scalerClock),
        .reset         (reset),
        .start         (start),
        .coordItem     (coordItem),
        .coordValid    (coordValid),
        .coordReady    (coordReady),
        .pixelReq      (pixelReq),
        .pixelAck      (pixelAck),
        .upstreamPixel (upstreamPixel),
        .blendItem     (blendItem),
        .blendValid    (blendValid),
        .blendReady    (blendReady)
    );

    scalerBlend scalerBlend_inst (
        .scalerClock (scalerClock),
        .reset       (reset),
        .blendItem   (blendItem),
        .blendValid  (blendValid),
        .blendReady  (blendReady),
        .outItem     (outItem),
        .outValid    (outValid),
        .outReady    (outReady)
    );

    scalerOutputPort scalerOutputPort_inst (
        .scalerClock (scalerClock),
        .reset       (reset),
        .outItem     (outItem),
        .outValid    (outValid),
        .outReady    (outReady),
        .outPixel    (outPixel),
        .outReq      (outReq),
        .outAck      (outAck),
        .lineDone    (lineDone)
    );

endmodule

/* scalerBlend.sv */
/*
 * Registered per-channel linear blend of the left and right pixels
 */
`timescale 1ns/100ps

module scalerBlend import scalerPkg::*; (
    input  logic       scalerClock,
    input  logic       reset,
    input  blendItem_t blendItem,
    input  logic       blendValid,
    output logic       blendReady,
    output outItem_t   outItem,
    output logic       outValid,
    input  logic       outReady
);

    logic [channelBits-1:0] mixedRed;
    logic [channelBits-1:0] mixedGreen;
    logic [channelBits-1:0] mixedBlue;
    logic transfer;

    // Weighted sum of one channel, truncated back to channel width
    function automatic logic [channelBits-1:0] mixChannel(
        input logic [channelBits-1:0] left,
        input logic [channelBits-1:0] right,
        input fraction_t fraction
    );
        logic [fractionBits:0] leftWeight;
        logic [channelBits+fractionBits-1:0] sum;
        leftWeight = (fractionBits+1)'(fractionOne) - fraction;
        // A zero fraction gives the left channel times 64, so it passes unchanged
        sum = left * leftWeight + right * fraction;
        return sum[channelBits+fractionBits-1:fractionBits];
    endfunction

    // Red and blue are zero-extended to the green width
    always_comb begin
        mixedRed = mixChannel({1'b0, blendItem.left[15:11]}, {1'b0, blendItem.right[15:11]},
                              blendItem.fraction);
        mixedGreen = mixChannel(blendItem.left[10:5], blendItem.right[10:5],
                                blendItem.fraction);
        mixedBlue = mixChannel({1'b0, blendItem.left[4:0]}, {1'b0, blendItem.right[4:0]},
                               blendItem.fraction);
    end

    // The held item may leave and be replaced in the same cycle
    assign blendReady = !outValid || outReady;
    assign transfer = blendValid && blendReady;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (transfer) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge scalerClock) begin
        if (transfer) begin
            outItem.pixel <= {mixedRed[4:0], mixedGreen, mixedBlue[4:0]};
            outItem.last <= blendItem.last;
        end
    end

endmodule

/* scalerCoordGen.sv */
/*
 * Coordinate generator that maps each output column to an upstream
 * coordinate and owns the line busy flag
 */
`timescale 1ns/100ps

module scalerCoordGen import scalerPkg::*; (
    input  logic       scalerClock,
    input  logic       reset,
    input  logic       start,
    input  shrink_t    shrinkFactor,
    input  column_t    outputWidth,
    output logic       busy,
    input  logic       lineDone,
    output coordItem_t coordItem,
    output logic       coordValid,
    input  logic       coordReady
);

    coord_t accumulator;
    coord_t centerOffset;
    shrink_t shrinkHeld;
    column_t columnCount;
    column_t lastColumn;
    logic startAccepted;
    logic transfer;

    // A start pulse during a line is dropped
    assign startAccepted = start && !busy;
    assign transfer = coordValid && coordReady;

    // Half the factor centers the sample, minus one half once the factor reaches 1.0
    assign centerOffset = coord_t'(shrinkFactor >> 1)
        - ((shrinkFactor >= shrink_t'(fractionOne)) ? coord_t'(fractionHalf) : '0);

    assign coordItem = '{
        column: accumulator[columnBits+fractionBits-1:fractionBits],
        fraction: accumulator[fractionBits-1:0],
        last: (columnCount == lastColumn)
    };

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            coordValid <= 1'b0;
        end else begin
            if (startAccepted) begin
                busy <= 1'b1;
                coordValid <= 1'b1;
            end else begin
                // The output port reports when the last pixel has left
                if (lineDone) begin
                    busy <= 1'b0;
                end
                if (transfer && coordItem.last) begin
                    coordValid <= 1'b0;
                end
            end
        end
    end

    // Accumulator and column count step once per accepted coordinate
    always_ff @(posedge scalerClock) begin
        if (startAccepted) begin
            shrinkHeld <= shrinkFactor;
            lastColumn <= outputWidth - column_t'(1);
            accumulator <= centerOffset;
            columnCount <= '0;
        end else if (transfer) begin
            accumulator <= accumulator + coord_t'(shrinkHeld);
            columnCount <= columnCount + column_t'(1);
        end
    end

endmodule

/* scalerOutputPort.sv */
/*
 * Output port that offers each blended pixel over a four-phase req/ack
 * handshake and flags the end of the line
 */
`timescale 1ns/100ps

module scalerOutputPort import scalerPkg::*; (
    input  logic     scalerClock,
    input  logic     reset,
    input  outItem_t outItem,
    input  logic     outValid,
    output logic     outReady,
    output pixel_t   outPixel,
    output logic     outReq,
    input  logic     outAck,
    output logic     lineDone
);

    portState_t state;
    outItem_t heldItem;

    // Only take a new pixel once the previous handshake has fully closed
    assign outReady = (state == portIdle);
    assign outReq = (state == portRequest);
    // Held register keeps the pixel stable for the whole request phase
    assign outPixel = heldItem.pixel;

    // Handshake of the final pixel closes when the sink drops its ack
    assign lineDone = (state == portRelease) && !outAck && heldItem.last;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= portIdle;
        end else begin
            case (state)
                portIdle: begin
                    if (outValid) begin
                        state <= portRequest;
                    end
                end
                portRequest: begin
                    if (outAck) begin
                        state <= portRelease;
                    end
                end
                portRelease: begin
                    if (!outAck) begin
                        state <= portIdle;
                    end
                end
                default: begin
                    state <= portIdle;
                end
            endcase
        end
    end

    always_ff @(posedge scalerClock) begin
        if (outValid && outReady) begin
            heldItem <= outItem;
        end
    end

endmodule

/* scalerPixelWindow.sv */
/*
 * Two-pixel upstream window that fetches pixels over a four-phase
 * req/ack port and pairs each coordinate with its left and right pixels
 */
`timescale 1ns/100ps

module scalerPixelWindow import scalerPkg::*; (
    input  logic       scalerClock,
    input  logic       reset,
    input  logic       start,
    input  coordItem_t coordItem,
    input  logic       coordValid,
    output logic       coordReady,
    output logic       pixelReq,
    input  logic       pixelAck,
    input  pixel_t     upstreamPixel,
    output blendItem_t blendItem,
    output logic       blendValid,
    input  logic       blendReady
);

    windowState_t state;
    pixel_t leftPixel;
    pixel_t rightPixel;
    column_t rightColumn;
    logic haveLeft;
    logic haveRight;
    logic fractionNonZero;
    logic pairMatch;
    logic rightMatch;
    logic satisfied;
    logic coordTransfer;
    logic fetchDone;

    assign fractionNonZero = |coordItem.fraction;

    // Left pixel at the whole column with its neighbour on the right
    assign pairMatch = haveLeft && haveRight
        && (rightColumn == coordItem.column + column_t'(1));
    // With a zero fraction the newest pixel alone is enough
    assign rightMatch = haveRight && (rightColumn == coordItem.column);

    assign satisfied = fractionNonZero ? pairMatch : (pairMatch || rightMatch);

    // A coordinate leaves once its pixels are held and the output register is free
    assign coordReady = satisfied && (!blendValid || blendReady);
    assign coordTransfer = coordValid && coordReady;

    assign pixelReq = (state == windowRequest);
    assign fetchDone = (state == windowRequest) && pixelAck;

    // Fetch FSM, one full four-phase handshake per refill
    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= windowIdle;
        end else begin
            case (state)
                windowIdle: begin
                    if (coordValid && !satisfied) begin
                        state <= windowRequest;
                    end
                end
                windowRequest: begin
                    if (pixelAck) begin
                        state <= windowRelease;
                    end
                end
                windowRelease: begin
                    // No new request until the source has dropped its ack
                    if (!pixelAck) begin
                        state <= windowIdle;
                    end
                end
                default: begin
                    state <= windowIdle;
                end
            endcase
        end
    end

    // Slot flags; a start between lines empties the window
    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            haveLeft <= 1'b0;
            haveRight <= 1'b0;
            blendValid <= 1'b0;
        end else begin
            if (start && !coordValid) begin
                haveLeft <= 1'b0;
                haveRight <= 1'b0;
            end else if (fetchDone) begin
                haveLeft <= haveRight;
                haveRight <= 1'b1;
            end
            if (coordTransfer) begin
                blendValid <= 1'b1;
            end else if (blendReady) begin
                blendValid <= 1'b0;
            end
        end
    end

    // New pixel enters on the right and the old right pixel moves left
    always_ff @(posedge scalerClock) begin
        if (fetchDone) begin
            leftPixel <= rightPixel;
            rightPixel <= upstreamPixel;
            rightColumn <= haveRight ? rightColumn + column_t'(1) : '0;
        end
        if (coordTransfer) begin
            blendItem.left <= (!fractionNonZero && rightMatch) ? rightPixel : leftPixel;
            blendItem.right <= rightPixel;
            blendItem.fraction <= coordItem.fraction;
            blendItem.last <= coordItem.last;
        end
    end

endmodule

/* scalerPkg.sv */
/*
 * Shared widths, fixed-point constants, pixel and coordinate types,
 * stage-to-stage item structs and handshake state encodings
 */
package scalerPkg;

    // One RGB 5-6-5 pixel
    localparam int unsigned pixelBits = 16;
    // Widest colour channel, which is green
    localparam int unsigned channelBits = 6;
    // Column index width, lines up to 2048 pixels
    localparam int unsigned columnBits = 11;
    // Fraction width of coordinates and of the shrink factor
    localparam int unsigned fractionBits = 6;

    // 1.0 and 0.5 in the fraction format
    localparam int unsigned fractionOne = 1 << fractionBits;
    localparam int unsigned fractionHalf = 1 << (fractionBits - 1);

    // Red sits in the top 5 bits, green in the middle 6 and blue in the bottom 5
    typedef logic [pixelBits-1:0] pixel_t;
    typedef logic [columnBits-1:0] column_t;
    typedef logic [fractionBits-1:0] fraction_t;
    // Shrink factor in 1.6 fixed point, 64 is unity
    typedef logic [fractionBits:0] shrink_t;
    // Upstream coordinate with whole column above the fraction
    typedef logic [columnBits+fractionBits-1:0] coord_t;

    // Coordinate generator to pixel window
    typedef struct packed {
        column_t column;
        fraction_t fraction;
        logic last;
    } coordItem_t;

    // Pixel window to blend stage
    typedef struct packed {
        pixel_t left;
        pixel_t right;
        fraction_t fraction;
        logic last;
    } blendItem_t;

    // Blend stage to output port
    typedef struct packed {
        pixel_t pixel;
        logic last;
    } outItem_t;

    // Upstream fetch handshake
    typedef enum logic [1:0] {
        windowIdle,
        windowRequest,
        windowRelease
    } windowState_t;

    // Downstream delivery handshake
    typedef enum logic [1:0] {
        portIdle,
        portRequest,
        portRelease
    } portState_t;

endpackage

/* tbHorizontalStretch.sv */
/*
 * Directed testbench for the horizontal scaler, with an upstream pixel
 * source, an output sink and a reference resampler
 */
`timescale 1ns/100ps

module tbHorizontalStretch import scalerPkg::*; ();

    localparam int lineDepth = 256;
    // Output widths of every line in the run set the cycle limit
    localparam int unityWidth = 40;
    localparam int stretchWidth = 64;
    localparam int shrinkWidth = 30;
    localparam int pressureWidth = 48;
    localparam int firstWidth = 24;
    localparam int secondWidth = 36;
    localparam int cycleLimit = (unityWidth + stretchWidth + shrinkWidth + pressureWidth
        + firstWidth + secondWidth) * 16 + 1000;

    logic scalerClock = 1'b0;
    logic reset;
    logic start;
    shrink_t shrinkFactor;
    column_t outputWidth;
    logic busy;
    logic pixelReq;
    logic pixelAck;
    pixel_t upstreamPixel;
    pixel_t outPixel;
    logic outReq;
    logic outAck;

    // Upstream line contents and the pixels collected by the sink
    pixel_t lineData [lineDepth];
    pixel_t received [$];
    int sourceIndex;
    bit useDelays;
    int errorCount;
    int failedTests;
    int cycleCount;

    always #10 scalerClock = ~scalerClock;

    horizontalStretch horizontalStretch_inst (
        .scalerClock   (scalerClock),
        .reset         (reset),
        .start         (start),
        .shrinkFactor  (shrinkFactor),
        .outputWidth   (outputWidth),
        .busy          (busy),
        .pixelReq      (pixelReq),
        .pixelAck      (pixelAck),
        .upstreamPixel (upstreamPixel),
        .outPixel      (outPixel),
        .outReq        (outReq),
        .outAck        (outAck)
    );

    // Upstream coordinate of output column k in 1.6 fixed point where 64 is 1.0
    function automatic int sourceCoordinate(input int k, input int factor);
        int coord;
        coord = k * factor + factor / 2;
        // Factors of 1.0 and above step back by one half
        if (factor >= 64) begin
            coord = coord - 32;
        end
        return coord;
    endfunction

    // Per-channel weighted mix truncated by the 6 fraction bits
    function automatic pixel_t mixPixel(input pixel_t left, input pixel_t right, input int frac);
        int red;
        int green;
        int blue;
        red = (int'(left[15:11]) * (64 - frac) + int'(right[15:11]) * frac) / 64;
        green = (int'(left[10:5]) * (64 - frac) + int'(right[10:5]) * frac) / 64;
        blue = (int'(left[4:0]) * (64 - frac) + int'(right[4:0]) * frac) / 64;
        return {red[4:0], green[5:0], blue[4:0]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsAtStart);
        if (errorCount == errorsAtStart) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    // Runs one line from a start pulse until busy falls and checks every pixel
    task automatic runLine(input int factor, input int width);
        int coord;
        int column;
        int fraction;
        pixel_t expected;
        received.delete();
        sourceIndex = 0;
        start <= 1'b1;
        shrinkFactor <= shrink_t'(factor);
        outputWidth <= column_t'(width);
        @(posedge scalerClock);
        start <= 1'b0;
        do @(posedge scalerClock); while (!busy);
        do @(posedge scalerClock); while (busy);
        if (received.size() != width) begin
            $display("Line with factor %0d gave %0d output pixels instead of %0d",
                     factor, received.size(), width);
            errorCount++;
        end
        for (int k = 0; k < width && k < received.size(); k++) begin
            coord = sourceCoordinate(k, factor);
            column = coord / 64;
            fraction = coord % 64;
            expected = mixPixel(lineData[column], lineData[column + 1], fraction);
            checkValue($sformatf("outPixel[%0d]", k), received[k], expected);
        end
        // The last column needs its right neighbour only for a nonzero fraction
        coord = sourceCoordinate(width - 1, factor);
        checkValue("pixelReq handshakes", sourceIndex,
                   coord / 64 + ((coord % 64 != 0) ? 2 : 1));
    endtask

    task automatic testUnityScale();
        int errorsAtStart;
        errorsAtStart = errorCount;
        for (int i = 0; i < lineDepth; i++) begin
            lineData[i] = pixel_t'(i * 16'h9e37 ^ 16'h3c5a);
        end
        runLine(64, unityWidth);
        finishTest("Unity scale", errorsAtStart);
    endtask

    task automatic testStretchTwo();
        int errorsAtStart;
        errorsAtStart = errorCount;
        // Ramp that rises in red and green and falls in blue
        for (int i = 0; i < lineDepth; i++) begin
            lineData[i] = {5'(i), 6'(i * 2), 5'(31 - i)};
        end
        runLine(32, stretchWidth);
        finishTest("Two-times stretch", errorsAtStart);
    endtask

    task automatic testShrink();
        int errorsAtStart;
        errorsAtStart = errorCount;
        for (int i = 0; i < lineDepth; i++) begin
            lineData[i] = pixel_t'(i * 16'h0843 + 16'h1234);
        end
        runLine(96, shrinkWidth);
        finishTest("Shrink", errorsAtStart);
    endtask

    task automatic testBackPressure();
        int errorsAtStart;
        int factor;
        errorsAtStart = errorCount;
        for (int i = 0; i < lineDepth; i++) begin
            lineData[i] = pixel_t'($urandom);
        end
        // Anything above one half up to just under two
        factor = $urandom_range(127, 33);
        useDelays = 1'b1;
        runLine(factor, pressureWidth);
        useDelays = 1'b0;
        finishTest("Back-pressure", errorsAtStart);
    endtask

    task automatic testConsecutiveLines();
        int errorsAtStart;
        errorsAtStart = errorCount;
        for (int i = 0; i < lineDepth; i++) begin
            lineData[i] = pixel_t'(i * 16'h2f1d ^ 16'hc3a5);
        end
        runLine(80, firstWidth);
        // One idle cycle without a start, so the scaler must rest between the lines
        @(posedge scalerClock);
        checkValue("busy", busy, 0);
        checkValue("pixelReq", pixelReq, 0);
        // New data makes a window left over from the first line show up
        for (int i = 0; i < lineDepth; i++) begin
            lineData[i] = pixel_t'(i * 16'h5b07 + 16'h0f0f);
        end
        runLine(48, secondWidth);
        finishTest("Consecutive lines", errorsAtStart);
    endtask

    // Upstream source answering each request with the next pixel of the line
    initial begin : upstreamSource
        int delay;
        forever begin
            @(posedge scalerClock);
            if (pixelReq && !pixelAck) begin
                delay = useDelays ? $urandom_range(3, 0) : 0;
                repeat (delay) @(posedge scalerClock);
                upstreamPixel <= lineData[sourceIndex % lineDepth];
                pixelAck <= 1'b1;
                sourceIndex++;
                // Ack stays up until the scaler has taken the pixel
                do @(posedge scalerClock); while (pixelReq);
                pixelAck <= 1'b0;
            end
        end
    end

    // Output sink that takes each offered pixel
    initial begin : outputSink
        int delay;
        forever begin
            @(posedge scalerClock);
            if (outReq && !outAck) begin
                delay = useDelays ? $urandom_range(3, 0) : 0;
                repeat (delay) @(posedge scalerClock);
                received.push_back(outPixel);
                outAck <= 1'b1;
                do @(posedge scalerClock); while (outReq);
                // A late ack release holds the output port and stalls the pipeline
                delay = useDelays ? $urandom_range(3, 0) : 0;
                repeat (delay) @(posedge scalerClock);
                outAck <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge scalerClock);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, a line never finished", cycleLimit);
        $display("test failed");
        $finish;
    end

    initial begin
        errorCount = 0;
        failedTests = 0;
        useDelays = 1'b0;
        sourceIndex = 0;
        void'($urandom(32'h6a94_ca4f));
        reset <= 1'b1;
        start <= 1'b0;
        shrinkFactor <= '0;
        outputWidth <= '0;
        pixelAck <= 1'b0;
        upstreamPixel <= '0;
        outAck <= 1'b0;
        repeat (8) @(posedge scalerClock);
        reset <= 1'b0;
        @(posedge scalerClock);
        testUnityScale();
        testStretchTwo();
        testShrink();
        testBackPressure();
        testConsecutiveLines();
        $display("Tests run: 5, tests failed: %0d, errors: %0d", failedTests, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
